/* chan_reg_pkg.sv */
// ========================================
// register map of the channel port
// field widths, reset values, host structs
// ========================================
package chan_reg_pkg;

	localparam int NUM_REGS    = 32; // registers on the master port
	localparam int REG_INDEX_W = 5;  // low bits of the latched number

	// register numbers
	localparam logic [REG_INDEX_W-1:0] REG_FILL_NUM     = 5'd0;  // initial fill number
	localparam logic [REG_INDEX_W-1:0] REG_CHAN_TAG     = 5'd1;  // channel tag, low 3 from jumpers
	localparam logic [REG_INDEX_W-1:0] REG_MUON_BURSTS  = 5'd2;
	localparam logic [REG_INDEX_W-1:0] REG_LASER_BURSTS = 5'd3;
	localparam logic [REG_INDEX_W-1:0] REG_PED_BURSTS   = 5'd4;
	localparam logic [REG_INDEX_W-1:0] REG_GENREG_ADDR  = 5'd5;  // generic register addr/ctrl
	localparam logic [REG_INDEX_W-1:0] REG_GENREG_WDATA = 5'd6;
	localparam logic [REG_INDEX_W-1:0] REG_GENREG_RDATA = 5'd7;  // read only
	localparam logic [REG_INDEX_W-1:0] REG_DELAY_TAP    = 5'd8;  // adc input delay tap
	localparam logic [REG_INDEX_W-1:0] REG_TAPS_LO      = 5'd9;  // lanes 0..4, read only
	localparam logic [REG_INDEX_W-1:0] REG_TAPS_MID     = 5'd10; // lanes 5..9, read only
	localparam logic [REG_INDEX_W-1:0] REG_TAPS_HI      = 5'd11; // lanes 10..12, read only
	localparam logic [REG_INDEX_W-1:0] REG_DELAY_STATUS = 5'd12; // delay error flag, read only
	// 13 to 31 are plain scratch

	localparam logic [31:0] DELAY_TAP_DEFAULT = 32'd14; // tap loaded into R8 at reset

	// master FPGA side of the port, plain strobes
	typedef struct packed {
		logic [31:0] rx_data;    // data or register number
		logic        reg_num_le; // latch rx_data as register number
		logic        wr_en;      // write selected register
		logic        rd_en;      // load tx_data from selected register
	} host_bus_t;

	// generic register pass-through
	typedef struct packed {
		logic [31:0] addr_ctrl; // from R5
		logic [31:0] wr_data;   // from R6
	} genreg_out_t;

endpackage

/* chan_acq_pkg.sv */
// ========================================
// acquisition settings and delay-tap types
// delay FSM states and timing constants
// ========================================
package chan_acq_pkg;

	localparam int FILL_NUM_W = 24; // fill number counter width
	localparam int BURST_W    = 21; // burst count width

	// settings handed to the acquisition FSM
	typedef struct packed {
		logic [15:0]        channel_tag;      // goes into the data header
		logic [BURST_W-1:0] num_muon_bursts;  // bursts in a muon fill
		logic [BURST_W-1:0] num_laser_bursts; // bursts in a laser fill
		logic [BURST_W-1:0] num_ped_bursts;   // bursts in a pedestal fill
	} acq_cfg_t;

	localparam int NUM_LANES = 13; // adc data lanes with their own delay line
	localparam int TAP_W     = 5;  // tap bits per lane

	// tap read-back of all lanes, lane 0 in the low bits
	typedef logic [NUM_LANES-1:0][TAP_W-1:0] lane_taps_t;

	// delay-line reset sequence
	typedef enum logic [1:0] {
		DLY_IDLE,   // waiting for a tap change
		DLY_PULSE,  // delay reset held high
		DLY_SETTLE, // let the delay lines pick up the tap
		DLY_CHECK   // compare lane taps
	} delay_state_t;

	localparam int DLY_RST_CYCLES    = 4; // reset pulse length in clocks
	localparam int DLY_SETTLE_CYCLES = 8; // wait before the lane check
	localparam int DLY_CNT_W         = 4; // covers the longer of the two waits

endpackage

/* register_block.sv */
`timescale 1ns/1ns
// ========================================
// host-accessible block of 32 registers
// write decode, settings outputs and the
// registered read-back mux
// ========================================
module register_block (
	input  logic                               clk,
	input  logic                               reset,
	input  chan_reg_pkg::host_bus_t            host,             // master FPGA strobes
	output logic [31:0]                        tx_data,          // read-back to master
	output logic                               illegal_reg_num,  // latched number out of range
	input  logic [2:0]                         ch_addr,          // channel jumpers
	input  logic [chan_acq_pkg::FILL_NUM_W-1:0] fill_num,        // live fill counter
	output chan_acq_pkg::acq_cfg_t             acq_cfg,
	output logic [chan_acq_pkg::FILL_NUM_W-1:0] initial_fill_num,
	output logic                               initial_fill_num_wr,
	output chan_reg_pkg::genreg_out_t          genreg,
	input  logic [31:0]                        genreg_rd_data,
	output logic [chan_acq_pkg::TAP_W-1:0]     delay_tap,        // requested tap from R8
	input  chan_acq_pkg::lane_taps_t           current_taps,     // tap read-back per lane
	input  logic                               delay_error       // from the delay FSM
);
	import chan_reg_pkg::*;
	import chan_acq_pkg::*;

	logic [31:0]            reg_num;          // full latched number, upper bits only flag errors
	logic [REG_INDEX_W-1:0] reg_idx;
	logic                   wr_hit;           // legal write to a writable register
	logic [31:0]            regs [NUM_REGS];  // read-only slots stay at zero
	logic [31:0]            rdbk;             // read-back mux output

	// registers 7 and 9..12 are driven from outside the block
	function automatic logic is_writable(input logic [REG_INDEX_W-1:0] idx);
		logic ro;
		ro = (idx == REG_GENREG_RDATA) ||
			((idx >= REG_TAPS_LO) && (idx <= REG_DELAY_STATUS));
		return !ro;
	endfunction

	// register number latch
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_num <= '0;
		end else if (host.reg_num_le) begin
			reg_num <= host.rx_data;
		end
	end

	assign reg_idx         = reg_num[REG_INDEX_W-1:0];
	assign illegal_reg_num = |reg_num[31:REG_INDEX_W]; // any high bit set

	assign wr_hit = host.wr_en && !illegal_reg_num && is_writable(reg_idx);

	// register storage
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= (i == int'(REG_DELAY_TAP)) ? DELAY_TAP_DEFAULT : 32'd0;
			end
		end else if (wr_hit) begin
			regs[reg_idx] <= host.rx_data;
		end
	end

	// R0 write strobe goes straight to the fill counter
	assign initial_fill_num_wr = host.wr_en && !illegal_reg_num && (reg_idx == REG_FILL_NUM);
	// counter loads on the writing edge so take the value off the bus then
	assign initial_fill_num = initial_fill_num_wr ? host.rx_data[FILL_NUM_W-1:0]
		: regs[REG_FILL_NUM][FILL_NUM_W-1:0];

	// acquisition settings
	assign acq_cfg.channel_tag      = {regs[REG_CHAN_TAG][15:3], ch_addr}; // low bits from jumpers
	assign acq_cfg.num_muon_bursts  = regs[REG_MUON_BURSTS][BURST_W-1:0];
	assign acq_cfg.num_laser_bursts = regs[REG_LASER_BURSTS][BURST_W-1:0];
	assign acq_cfg.num_ped_bursts   = regs[REG_PED_BURSTS][BURST_W-1:0];

	// generic register interface
	assign genreg.addr_ctrl = regs[REG_GENREG_ADDR];
	assign genreg.wr_data   = regs[REG_GENREG_WDATA];

	assign delay_tap = regs[REG_DELAY_TAP][TAP_W-1:0]; // same tap for every lane

	// read-back selection
	always_comb begin
		case (reg_idx)
			REG_FILL_NUM: begin
				rdbk = {{(32-FILL_NUM_W){1'b0}}, fill_num}; // live counter, not the stored start
			end
			REG_CHAN_TAG: begin
				rdbk = {16'h0000, regs[REG_CHAN_TAG][15:3], ch_addr};
			end
			REG_MUON_BURSTS: begin
				rdbk = {{(32-BURST_W){1'b0}}, regs[REG_MUON_BURSTS][BURST_W-1:0]};
			end
			REG_LASER_BURSTS: begin
				rdbk = {{(32-BURST_W){1'b0}}, regs[REG_LASER_BURSTS][BURST_W-1:0]};
			end
			REG_PED_BURSTS: begin
				rdbk = {{(32-BURST_W){1'b0}}, regs[REG_PED_BURSTS][BURST_W-1:0]};
			end
			REG_GENREG_RDATA: begin
				rdbk = genreg_rd_data; // from the generic register target
			end
			REG_TAPS_LO: begin
				rdbk = {{(32-5*TAP_W){1'b0}}, current_taps[4:0]};   // lanes 0..4
			end
			REG_TAPS_MID: begin
				rdbk = {{(32-5*TAP_W){1'b0}}, current_taps[9:5]};   // lanes 5..9
			end
			REG_TAPS_HI: begin
				rdbk = {{(32-3*TAP_W){1'b0}}, current_taps[12:10]}; // lanes 10..12
			end
			REG_DELAY_STATUS: begin
				rdbk = {31'd0, delay_error};
			end
			default: begin
				rdbk = regs[reg_idx]; // R5, R6, R8 and scratch
			end
		endcase
	end

	// tx_data holds until the next read strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_data <= '0;
		end else if (host.rd_en) begin
			tx_data <= illegal_reg_num ? 32'd0 : rdbk; // bad number reads zero
		end
	end

endmodule

/* fill_counter.sv */
`timescale 1ns/1ns
// ========================================
// fill number counter
// loads from R0, counts fill triggers
// ========================================
module fill_counter (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [chan_acq_pkg::FILL_NUM_W-1:0] initial_fill_num, // start value from R0
	input  logic                                initial_fill_num_wr, // R0 write strobe
	input  logic                                fill_trig,        // one pulse per fill
	output logic [chan_acq_pkg::FILL_NUM_W-1:0] fill_num
);
	import chan_acq_pkg::*;

	logic [FILL_NUM_W-1:0] fill_next;

	// wraps to zero past the top value
	assign fill_next = fill_num + {{(FILL_NUM_W-1){1'b0}}, 1'b1};

	always_ff @(posedge clk) begin
		if (reset) begin
			fill_num <= {FILL_NUM_W{1'b0}};
		end else if (initial_fill_num_wr) begin
			fill_num <= initial_fill_num; // load beats a trigger on the same edge
		end else if (fill_trig) begin
			fill_num <= fill_next;
		end
	end

endmodule

/* data_delay_reset.sv */
`timescale 1ns/1ns
// ========================================
// delay-line reset FSM
// pulses reset on a tap change and checks
// the lane taps reported back
// ========================================
module data_delay_reset (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [chan_acq_pkg::TAP_W-1:0] delay_tap,        // requested tap
	input  chan_acq_pkg::lane_taps_t       current_taps,     // taps the lanes report
	output logic                           delay_data_reset, // to the delay primitives
	output logic                           delay_error       // some lane missed the tap
);
	import chan_acq_pkg::*;

	delay_state_t         state;
	logic [DLY_CNT_W-1:0] cnt;         // cycles spent in the current state
	logic [TAP_W-1:0]     applied_tap; // tap of the last sequence
	logic                 tap_mismatch;

	// any lane off the applied tap
	always_comb begin
		tap_mismatch = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (current_taps[i] != applied_tap) begin
				tap_mismatch = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= DLY_IDLE;
			cnt         <= '0;
			applied_tap <= '0; // forces one sequence after start-up
			delay_error <= 1'b0;
		end else begin
			case (state)
				DLY_IDLE: begin
					cnt <= '0;
					if (delay_tap != applied_tap) begin
						applied_tap <= delay_tap; // later changes wait for the next idle
						state       <= DLY_PULSE;
					end
				end
				DLY_PULSE: begin
					if (cnt == DLY_CNT_W'(DLY_RST_CYCLES - 1)) begin
						cnt   <= '0;
						state <= DLY_SETTLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				DLY_SETTLE: begin
					if (cnt == DLY_CNT_W'(DLY_SETTLE_CYCLES - 1)) begin
						cnt   <= '0;
						state <= DLY_CHECK;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin // DLY_CHECK, single cycle
					delay_error <= tap_mismatch;
					state       <= DLY_IDLE;
				end
			endcase
		end
	end

	assign delay_data_reset = (state == DLY_PULSE); // high for the whole pulse state

endmodule

/* chan_ctrl_top.sv */
`timescale 1ns/1ns
// ========================================
// channel slow-control top level
// register block, fill counter, delay FSM
// ========================================
module chan_ctrl_top (
	input  logic                                clk,
	input  logic                                reset,
	input  chan_reg_pkg::host_bus_t             host,             // master FPGA port
	output logic [31:0]                         tx_data,
	output logic                                illegal_reg_num,
	output chan_acq_pkg::acq_cfg_t              acq_cfg,          // to the acquisition FSM
	output logic [chan_acq_pkg::FILL_NUM_W-1:0] fill_num,
	input  logic                                fill_trig,
	input  logic [2:0]                          ch_addr,          // board jumpers
	output chan_reg_pkg::genreg_out_t           genreg,
	input  logic [31:0]                         genreg_rd_data,
	output logic [chan_acq_pkg::TAP_W-1:0]      delay_tap,        // to the delay primitives
	output logic                                delay_data_reset,
	input  chan_acq_pkg::lane_taps_t            current_taps      // tap read-back
);
	import chan_acq_pkg::*;

	logic [FILL_NUM_W-1:0] initial_fill_num;
	logic                  initial_fill_num_wr;
	logic                  delay_error;

	register_block i_register_block (
		.clk                 (clk),
		.reset               (reset),
		.host                (host),
		.tx_data             (tx_data),
		.illegal_reg_num     (illegal_reg_num),
		.ch_addr             (ch_addr),
		.fill_num            (fill_num),
		.acq_cfg             (acq_cfg),
		.initial_fill_num    (initial_fill_num),
		.initial_fill_num_wr (initial_fill_num_wr),
		.genreg              (genreg),
		.genreg_rd_data      (genreg_rd_data),
		.delay_tap           (delay_tap),
		.current_taps        (current_taps),
		.delay_error         (delay_error)
	);

	fill_counter i_fill_counter (
		.clk                 (clk),
		.reset               (reset),
		.initial_fill_num    (initial_fill_num),
		.initial_fill_num_wr (initial_fill_num_wr),
		.fill_trig           (fill_trig),
		.fill_num            (fill_num)
	);

	// status comes back to R12
	data_delay_reset i_data_delay_reset (
		.clk              (clk),
		.reset            (reset),
		.delay_tap        (delay_tap),
		.current_taps     (current_taps),
		.delay_data_reset (delay_data_reset),
		.delay_error      (delay_error)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns
// ========================================
// testbench clock and reset source
// 20 ns clock, reset held for 8 cycles
// ========================================
module tb_clock_gen (
	output logic clk,
	output logic reset
);
	localparam int HALF_PERIOD  = 10; // ns
	localparam int RESET_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0; // released just after the 8th edge
	end

endmodule

/* chan_ctrl_tb.sv */
`timescale 1ns/1ns
// ========================================
// testbench of the channel control top
// register table, illegal numbers, fill
// counter, delay FSM and pass-through reads
// ========================================
module chan_ctrl_tb;
	import chan_reg_pkg::*;
	import chan_acq_pkg::*;

	localparam int TIMEOUT_CYCLES = 100;
	localparam int NUM_ENTRIES    = 12;
	localparam int FILL_PULSES    = 5;

	typedef struct packed {
		logic [REG_INDEX_W-1:0] num;    // register number
		logic [31:0]            wdata;  // value written
		logic [31:0]            rd_exp; // expected read-back
	} table_entry_t;

	logic                  clk;
	logic                  reset;
	host_bus_t             host;
	logic [31:0]           tx_data;
	logic                  illegal_reg_num;
	acq_cfg_t              acq_cfg;
	logic [FILL_NUM_W-1:0] fill_num;
	logic                  fill_trig;
	logic [2:0]            ch_addr;
	genreg_out_t           genreg;
	logic [31:0]           genreg_rd_data;
	logic [TAP_W-1:0]      delay_tap;
	logic                  delay_data_reset;
	lane_taps_t            current_taps;

	table_entry_t reg_table [NUM_ENTRIES];
	logic [31:0]  scratch [NUM_REGS]; // values written to R13..R31
	logic [31:0]  lcg_state;
	logic [31:0]  got;
	logic [31:0]  exp_val;
	int           pulse_len;
	int           errors;
	int           timeouts;

	tb_clock_gen i_tb_clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	chan_ctrl_top i_chan_ctrl_top (
		.clk              (clk),
		.reset            (reset),
		.host             (host),
		.tx_data          (tx_data),
		.illegal_reg_num  (illegal_reg_num),
		.acq_cfg          (acq_cfg),
		.fill_num         (fill_num),
		.fill_trig        (fill_trig),
		.ch_addr          (ch_addr),
		.genreg           (genreg),
		.genreg_rd_data   (genreg_rd_data),
		.delay_tap        (delay_tap),
		.delay_data_reset (delay_data_reset),
		.current_taps     (current_taps)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// R9..R11 view of the driven lane taps with the lowest lane in the low bits
	function automatic logic [31:0] taps_slice(input lane_taps_t taps, input int first,
		input int count);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < count; i++) begin
			v[i*TAP_W +: TAP_W] = taps[first+i];
		end
		return v;
	endfunction

	task automatic tick(); // inputs change 2 ns after the edge
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_waited(input string what, input int n);
		assert (n < TIMEOUT_CYCLES) else begin
			timeouts++;
			$display("timeout: gave up waiting for %s", what);
		end
	endtask

	task automatic set_all_taps(input logic [TAP_W-1:0] tap);
		for (int i = 0; i < NUM_LANES; i++) begin
			current_taps[i] = tap;
		end
	endtask

	task automatic select_reg(input logic [31:0] num);
		host.rx_data    = num;
		host.reg_num_le = 1'b1;
		tick();
		host.reg_num_le = 1'b0;
	endtask

	task automatic strobe_write(input logic [31:0] data);
		host.rx_data = data;
		host.wr_en   = 1'b1;
		tick();
		host.wr_en   = 1'b0;
	endtask

	task automatic strobe_read(output logic [31:0] data);
		host.rd_en = 1'b1;
		tick();
		host.rd_en = 1'b0;
		data       = tx_data; // loaded on the read edge
	endtask

	task automatic write_reg(input logic [REG_INDEX_W-1:0] num, input logic [31:0] data);
		select_reg(32'(num));
		strobe_write(data);
	endtask

	task automatic read_reg(input logic [REG_INDEX_W-1:0] num, output logic [31:0] data);
		select_reg(32'(num));
		strobe_read(data);
	endtask

	// length of the next delay reset pulse in clocks
	task automatic measure_reset_pulse(output int width);
		int n;
		n     = 0;
		width = 0;
		while (delay_data_reset !== 1'b1 && n < TIMEOUT_CYCLES) begin
			tick();
			n++;
		end
		check_waited("the delay reset to rise", n);
		n = 0;
		while (delay_data_reset === 1'b1 && n < TIMEOUT_CYCLES) begin
			tick();
			width++;
			n++;
		end
		check_waited("the delay reset to fall", n);
	endtask

	task automatic fill_table(); // ch_addr is 5 and all lanes at tap 14 here
		reg_table[0]  = '{REG_CHAN_TAG,     32'hABCD_1234, 32'h0000_1235};
		reg_table[1]  = '{REG_MUON_BURSTS,  32'hFFFF_FFFF, 32'h001F_FFFF};
		reg_table[2]  = '{REG_LASER_BURSTS, 32'h1234_5678, 32'h0014_5678};
		reg_table[3]  = '{REG_PED_BURSTS,   32'h0020_0001, 32'h0000_0001}; // bit 21 dropped
		reg_table[4]  = '{REG_GENREG_ADDR,  32'hDEAD_BEEF, 32'hDEAD_BEEF};
		reg_table[5]  = '{REG_GENREG_WDATA, 32'hCAFE_F00D, 32'hCAFE_F00D};
		reg_table[6]  = '{REG_DELAY_TAP,    32'h1234_00EE, 32'h1234_00EE}; // tap stays 14
		reg_table[7]  = '{REG_GENREG_RDATA, 32'hFFFF_FFFF, 32'h5A5A_0F0F};
		reg_table[8]  = '{REG_TAPS_LO,      32'hFFFF_FFFF, 32'h00E7_39CE};
		reg_table[9]  = '{REG_TAPS_MID,     32'hFFFF_FFFF, 32'h00E7_39CE};
		reg_table[10] = '{REG_TAPS_HI,      32'hFFFF_FFFF, 32'h0000_39CE};
		reg_table[11] = '{REG_DELAY_STATUS, 32'hFFFF_FFFF, 32'h0000_0000};
	endtask

	initial begin
		int n;
		host           = '0;
		fill_trig      = 1'b0;
		ch_addr        = 3'd5;
		genreg_rd_data = 32'd0;
		errors         = 0;
		timeouts       = 0;
		lcg_state      = 32'd91; // seed
		set_all_taps(5'd14);
		fill_table();
		n = 0;
		while (reset !== 1'b0 && n < TIMEOUT_CYCLES) begin
			tick();
			n++;
		end
		check_waited("reset release", n);

		// start-up delay sequence with tap 14 and then the reset values
		measure_reset_pulse(pulse_len);
		check_value("startup reset pulse width", 32'd4, 32'(pulse_len));
		repeat (DLY_SETTLE_CYCLES + 3) tick(); // settle, check and margin
		for (int r = 0; r < NUM_REGS; r++) begin
			read_reg(r[REG_INDEX_W-1:0], got);
			case (r)
				1: exp_val = 32'(ch_addr);
				8: exp_val = 32'd14;
				9: exp_val = taps_slice(current_taps, 0, 5);
				10: exp_val = taps_slice(current_taps, 5, 5);
				11: exp_val = taps_slice(current_taps, 10, 3);
				default: exp_val = 32'd0; // genreg_rd_data still zero for R7
			endcase
			check_value($sformatf("reset value R%0d", r), exp_val, got);
		end

		// register table where read-only rows keep their read-back
		genreg_rd_data = 32'h5A5A_0F0F;
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			write_reg(reg_table[e].num, reg_table[e].wdata);
			read_reg(reg_table[e].num, got);
			check_value($sformatf("table R%0d", reg_table[e].num), reg_table[e].rd_exp, got);
		end
		check_value("channel_tag", 32'h0000_1235, 32'(acq_cfg.channel_tag));
		check_value("muon bursts", 32'h001F_FFFF, 32'(acq_cfg.num_muon_bursts));
		check_value("laser bursts", 32'h0014_5678, 32'(acq_cfg.num_laser_bursts));
		check_value("pedestal bursts", 32'h0000_0001, 32'(acq_cfg.num_ped_bursts));
		check_value("genreg addr_ctrl", 32'hDEAD_BEEF, genreg.addr_ctrl);
		check_value("genreg wr_data", 32'hCAFE_F00D, genreg.wr_data);
		check_value("delay tap", 32'd14, 32'(delay_tap));
		ch_addr = 3'd2; // jumpers feed the tag without a clock
		#1;
		check_value("channel_tag jumpers", 32'd2, 32'(acq_cfg.channel_tag[2:0]));
		for (int r = 13; r < NUM_REGS; r++) begin
			lcg_state  = lcg_next(lcg_state);
			scratch[r] = lcg_state;
			write_reg(r[REG_INDEX_W-1:0], scratch[r]);
		end
		for (int r = 13; r < NUM_REGS; r++) begin
			read_reg(r[REG_INDEX_W-1:0], got);
			check_value($sformatf("scratch R%0d", r), scratch[r], got);
		end

		// illegal register number whose low bits point at R3
		select_reg(32'h8000_0003);
		check_value("illegal flag set", 32'd1, 32'(illegal_reg_num));
		strobe_write(32'h0000_0777);
		strobe_read(got);
		check_value("illegal read", 32'd0, got);
		read_reg(REG_LASER_BURSTS, got);
		check_value("illegal flag cleared", 32'd0, 32'(illegal_reg_num));
		check_value("R3 after illegal write", 32'h0014_5678, got);

		// fill counter across the wrap point
		write_reg(REG_FILL_NUM, 32'h00FF_FFFD);
		read_reg(REG_FILL_NUM, got);
		check_value("fill load", 32'h00FF_FFFD, got);
		for (int k = 0; k < FILL_PULSES; k++) begin
			fill_trig = 1'b1;
			tick();
			fill_trig = 1'b0;
			tick();
		end
		exp_val = (32'h00FF_FFFD + 32'(FILL_PULSES)) & 32'h00FF_FFFF; // modulo 2**24
		read_reg(REG_FILL_NUM, got);
		check_value("fill after triggers", exp_val, got);
		check_value("fill_num output", exp_val, 32'(fill_num));

		// delay tap change that all lanes follow
		set_all_taps(5'd21);
		write_reg(REG_DELAY_TAP, 32'd21);
		measure_reset_pulse(pulse_len);
		check_value("tap 21 reset pulse width", 32'd4, 32'(pulse_len));
		repeat (DLY_SETTLE_CYCLES + 3) tick();
		read_reg(REG_DELAY_STATUS, got);
		check_value("tap 21 delay status", 32'd0, got);
		// one lane misses the new tap
		set_all_taps(5'd7);
		current_taps[6] = 5'd8;
		write_reg(REG_DELAY_TAP, 32'd7);
		measure_reset_pulse(pulse_len);
		check_value("tap 7 reset pulse width", 32'd4, 32'(pulse_len));
		repeat (DLY_SETTLE_CYCLES + 3) tick();
		read_reg(REG_DELAY_STATUS, got);
		check_value("tap 7 delay status", 32'd1, got);

		// pass-through read-back with random values
		lcg_state      = lcg_next(lcg_state);
		genreg_rd_data = lcg_state;
		for (int i = 0; i < NUM_LANES; i++) begin
			lcg_state       = lcg_next(lcg_state);
			current_taps[i] = lcg_state[20:16]; // upper bits are less regular
		end
		read_reg(REG_GENREG_RDATA, got);
		check_value("genreg read data", genreg_rd_data, got);
		read_reg(REG_TAPS_LO, got);
		check_value("taps lanes 0-4", taps_slice(current_taps, 0, 5), got);
		read_reg(REG_TAPS_MID, got);
		check_value("taps lanes 5-9", taps_slice(current_taps, 5, 5), got);
		read_reg(REG_TAPS_HI, got);
		check_value("taps lanes 10-12", taps_slice(current_taps, 10, 3), got);

		$display("summary: %0d wrong values, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* build.f */
chan_reg_pkg.sv
chan_acq_pkg.sv
register_block.sv
fill_counter.sv
data_delay_reset.sv
chan_ctrl_top.sv
tb_clock_gen.sv
chan_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the channel control testbench with Verilator
# exits 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

TOP=chan_ctrl_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
